/* hw/tile_defines.svh */
/*
 * Fixed configuration of the compute tile: bus widths, address windows,
 * data memory size, UART bit timing, register offsets and interrupt position
 */

`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Wishbone bus widths
`define WB_ADR_W 32
`define WB_DAT_W 32
`define WB_SEL_W 4

// Interrupt vector of the core
`define IRQ_W 32
`define UART_IRQ_BIT 2

// DM window is every address with this bit clear
`define DM_MATCH_BIT 31
`define DM_AW 8                   // 256 words, higher addresses alias

// UART window is 16 bytes from the base
`define UART_BASE 32'h9000_0000
`define UART_ADR_MASK 32'hffff_fff0

// Serial bit timing
`define UART_DIV 4                // Clocks per serial bit
`define UART_CNT_W 2              // Must hold UART_DIV-1

// UART register word offsets, address bits 3:2
`define UART_REG_TX 2'd0
`define UART_REG_STAT 2'd1
`define UART_REG_IEN 2'd2

`endif

/* hw/tile_pkg.sv */
/*
 * Shared types of the compute tile
 * Slave select for the address decoder and UART transmit FSM states
 */

package tile_pkg;

   // Target of the current bus request
   typedef enum logic [1:0] {
      SLV_DM   = 2'd0,            // Data memory
      SLV_UART = 2'd1,            // UART register block
      SLV_NONE = 2'd2             // Unmapped, answered with err
   } slave_sel_e;

   // UART serializer states
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,            // Line idles high
      TX_START = 2'd1,            // Start bit
      TX_DATA  = 2'd2,            // Eight data bits, LSB first
      TX_STOP  = 2'd3             // Stop bit
   } uart_tx_state_e;

endpackage

/* hw/wb_addr_decode.sv */
/*
 * Address decoder of the tile bus
 * Maps the request address onto the DM or UART window and drives one strobe
 * per slave
 * Unmapped addresses select no slave
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module wb_addr_decode (
   input  logic [`WB_ADR_W-1:0] adr_i,
   input  logic                 cyc_i,
   input  logic                 stb_i,
   output tile_pkg::slave_sel_e sel_slave_o,
   output logic                 dm_stb_o,
   output logic                 uart_stb_o
);

   logic req;                     // Valid cycle on the bus
   logic dm_hit;
   logic uart_hit;

   assign req = cyc_i & stb_i;

   // DM covers the lower half of the address space
   assign dm_hit = ~adr_i[`DM_MATCH_BIT];
   assign uart_hit = ((adr_i & `UART_ADR_MASK) == `UART_BASE);

   // DM takes priority in the select
   always_comb begin
      if (dm_hit) begin
         sel_slave_o = tile_pkg::SLV_DM;
      end else if (uart_hit) begin
         sel_slave_o = tile_pkg::SLV_UART;
      end else begin
         sel_slave_o = tile_pkg::SLV_NONE;
      end
   end

   assign dm_stb_o = req & dm_hit;
   assign uart_stb_o = req & uart_hit;

   // The address windows from the defines must stay disjoint
   always_comb begin
      assert (!(dm_stb_o && uart_stb_o))
         else $error("decode: DM and UART strobes both high at %h", adr_i);
   end

endmodule

/* hw/dm_ram.sv */
/*
 * Data memory slave
 * Word array with byte select writes, registered read data and a one-cycle
 * acknowledge per strobe
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module dm_ram (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  logic [`DM_AW-1:0]    adr_i,
   input  logic [`WB_SEL_W-1:0] sel_i,
   input  logic [`WB_DAT_W-1:0] dat_i,
   output logic [`WB_DAT_W-1:0] dat_o,
   output logic                 ack_o
);

   logic [`WB_DAT_W-1:0] mem [0:(2**`DM_AW)-1];
   logic                 access;  // Strobe not yet answered

   // Answer once, the master drops stb after seeing ack
   assign access = stb_i & ~ack_o;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   // Byte lanes written only where the select is set
   always_ff @(posedge clk) begin
      if (access && we_i) begin
         for (int b = 0; b < `WB_SEL_W; b++) begin
            if (sel_i[b]) begin
               mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
            end
         end
      end
   end

   // Old word returned on a write cycle, the master ignores it
   always_ff @(posedge clk) begin
      if (access) begin
         dat_o <= mem[adr_i];
      end
   end

endmodule

/* hw/uart_regs.sv */
/*
 * UART register block
 * TX data, status and interrupt enable registers, a transmit serializer
 * with baud counter, and the tx-done interrupt
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module uart_regs (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  logic [1:0]           reg_i,
   input  logic [7:0]           dat_i,
   output logic [`WB_DAT_W-1:0] dat_o,
   output logic                 ack_o,
   output logic                 err_o,
   output logic                 irq_o,
   output logic                 tx_o
);

   tile_pkg::uart_tx_state_e tx_state;
   logic [`UART_CNT_W-1:0]   baud_cnt;
   logic                     baud_tick;   // Last cycle of a serial bit
   logic [2:0]               bit_cnt;
   logic [7:0]               shift_q;
   logic                     busy;
   logic                     done_q;      // Sticky, cleared by STAT read
   logic                     ien_q;
   logic                     access;
   logic                     tx_wr;
   logic                     tx_start;
   logic                     stat_rd;

   assign access = stb_i & ~ack_o & ~err_o;
   assign busy = (tx_state != tile_pkg::TX_IDLE);
   assign tx_wr = access & we_i & (reg_i == `UART_REG_TX);
   assign tx_start = tx_wr & ~busy;
   assign stat_rd = access & ~we_i & (reg_i == `UART_REG_STAT);
   assign baud_tick = (baud_cnt == `UART_CNT_W'(`UART_DIV - 1));
   assign irq_o = done_q & ien_q;

   // Bus response, TX write while busy is refused
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         ien_q <= 1'b0;
      end else begin
         ack_o <= access & ~(tx_wr & busy);
         err_o <= tx_wr & busy;
         if (access && we_i && (reg_i == `UART_REG_IEN)) begin
            ien_q <= dat_i[0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_i)
            `UART_REG_STAT: dat_o <= {30'b0, done_q, busy};
            `UART_REG_IEN:  dat_o <= {31'b0, ien_q};
            default:        dat_o <= '0;
         endcase
      end
   end

   // Transmit FSM, one state step per baud tick
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         tx_state <= tile_pkg::TX_IDLE;
         baud_cnt <= '0;
         bit_cnt <= '0;
         tx_o <= 1'b1;
         done_q <= 1'b0;
      end else begin
         if (stat_rd) begin
            done_q <= 1'b0;
         end
         if (tx_state == tile_pkg::TX_IDLE) begin
            baud_cnt <= '0;
            if (tx_start) begin
               tx_state <= tile_pkg::TX_START;
               tx_o <= 1'b0;             // Start bit
            end
         end else if (!baud_tick) begin
            baud_cnt <= baud_cnt + 1'b1;
         end else begin
            baud_cnt <= '0;
            case (tx_state)
               tile_pkg::TX_START: begin
                  tx_state <= tile_pkg::TX_DATA;
                  tx_o <= shift_q[0];
                  bit_cnt <= '0;
               end
               tile_pkg::TX_DATA: begin
                  if (bit_cnt == 3'd7) begin
                     tx_state <= tile_pkg::TX_STOP;
                     tx_o <= 1'b1;       // Stop bit
                  end else begin
                     tx_o <= shift_q[0];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
               default: begin
                  tx_state <= tile_pkg::TX_IDLE;
                  done_q <= 1'b1;        // Set wins over a STAT read
               end
            endcase
         end
      end
   end

   // Shifter feeds the next data bit on every tick of START and DATA
   always_ff @(posedge clk) begin
      if (tx_start) begin
         shift_q <= dat_i;
      end else if (baud_tick && (tx_state == tile_pkg::TX_START ||
                                 tx_state == tile_pkg::TX_DATA)) begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
   end

   a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ack_o && err_o));

   // Line must be back at mark whenever the FSM rests
   a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
      (tx_state == tile_pkg::TX_IDLE) |-> tx_o);

endmodule

/* hw/wb_resp_mux.sv */
/*
 * Response return of the tile bus
 * Routes ack, err and read data of the selected slave back to the master
 * and answers unmapped addresses with a one-shot err
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module wb_resp_mux (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 stb_i,
   input  tile_pkg::slave_sel_e sel_slave_i,
   input  logic [`WB_DAT_W-1:0] dm_dat_i,
   input  logic                 dm_ack_i,
   input  logic [`WB_DAT_W-1:0] uart_dat_i,
   input  logic                 uart_ack_i,
   input  logic                 uart_err_i,
   output logic [`WB_DAT_W-1:0] dat_o,
   output logic                 ack_o,
   output logic                 err_o
);

   logic none_err;                // Unmapped address answer

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         none_err <= 1'b0;
      end else begin
         none_err <= stb_i & (sel_slave_i == tile_pkg::SLV_NONE) & ~none_err;
      end
   end

   // Address is still held while the slave answers
   always_comb begin
      dat_o = '0;
      ack_o = 1'b0;
      err_o = none_err;
      case (sel_slave_i)
         tile_pkg::SLV_DM: begin
            dat_o = dm_dat_i;
            ack_o = dm_ack_i;
         end
         tile_pkg::SLV_UART: begin
            dat_o = uart_dat_i;
            ack_o = uart_ack_i;
            err_o = none_err | uart_err_i;
         end
         default: ;
      endcase
   end

   a_resp_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ack_o && err_o));

endmodule

/* hw/compute_tile_top.sv */
/*
 * Compute tile bus side
 * Address decoder, DM and UART slaves, response return and the core
 * interrupt vector
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module compute_tile_top (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic [`WB_ADR_W-1:0] wb_adr_i,
   input  logic [`WB_DAT_W-1:0] wb_dat_i,
   input  logic [`WB_SEL_W-1:0] wb_sel_i,
   input  logic                 wb_we_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   output logic [`WB_DAT_W-1:0] wb_dat_o,
   output logic                 wb_ack_o,
   output logic                 wb_err_o,
   output logic [`IRQ_W-1:0]    irq_o,
   output logic                 uart_tx_o
);

   tile_pkg::slave_sel_e sel_slave;
   logic                 dm_stb;
   logic                 uart_stb;
   logic [`WB_DAT_W-1:0] dm_dat;
   logic                 dm_ack;
   logic [`WB_DAT_W-1:0] uart_dat;
   logic                 uart_ack;
   logic                 uart_err;
   logic                 uart_irq;

   wb_addr_decode u_decode (
      .adr_i       (wb_adr_i),
      .cyc_i       (wb_cyc_i),
      .stb_i       (wb_stb_i),
      .sel_slave_o (sel_slave),
      .dm_stb_o    (dm_stb),
      .uart_stb_o  (uart_stb)
   );

   dm_ram u_dm (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (dm_stb),
      .we_i    (wb_we_i),
      .adr_i   (wb_adr_i[`DM_AW+1:2]),  // Word address, aliases above
      .sel_i   (wb_sel_i),
      .dat_i   (wb_dat_i),
      .dat_o   (dm_dat),
      .ack_o   (dm_ack)
   );

   uart_regs u_uart (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (uart_stb),
      .we_i    (wb_we_i),
      .reg_i   (wb_adr_i[3:2]),
      .dat_i   (wb_dat_i[7:0]),
      .dat_o   (uart_dat),
      .ack_o   (uart_ack),
      .err_o   (uart_err),
      .irq_o   (uart_irq),
      .tx_o    (uart_tx_o)
   );

   wb_resp_mux u_resp (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .stb_i       (wb_cyc_i & wb_stb_i),
      .sel_slave_i (sel_slave),
      .dm_dat_i    (dm_dat),
      .dm_ack_i    (dm_ack),
      .uart_dat_i  (uart_dat),
      .uart_ack_i  (uart_ack),
      .uart_err_i  (uart_err),
      .dat_o       (wb_dat_o),
      .ack_o       (wb_ack_o),
      .err_o       (wb_err_o)
   );

   // Only the UART interrupts the core, other bits unused
   always_comb begin
      irq_o = '0;
      irq_o[`UART_IRQ_BIT] = uart_irq;
   end

endmodule

/* verif/tb_clkgen.sv */
/*
 * Testbench clock source with an 8 ns period
 */

`timescale 1ns/10ps

module tb_clkgen (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   always #4 clk_o = ~clk_o;      // Half of the 8 ns period

endmodule

/* verif/tb_top.sv */
/*
 * Testbench of the compute tile
 * Vector driven bus cycles, UART frame and interrupt checks, random DM sweep
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module tb_top;

   logic        clk;
   logic        rst_n_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_we_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic [31:0] irq_o;
   logic        uart_tx_o;
   integer      seed = 32'hebe17bcd;
   logic [31:0] dm_model [0:15];  // Expected DM words 0x40 to 0x4f

   tb_clkgen u_clkgen (.clk_o(clk));

   compute_tile_top u_dut (.*);

   task automatic fail_stop();
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         fail_stop();
      end
   endtask

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] sel);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // Starts on a falling edge and ends one falling edge after the response
   task automatic bus_cycle(input string name, input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rdat, output logic got_err);
      int cnt;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_we_i = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      for (cnt = 1; cnt <= 16; cnt++) begin
         @(negedge clk);
         if (wb_ack_o || wb_err_o) begin
            break;
         end
      end
      if (cnt > 16) begin
         $display("ERROR: %s got neither ack nor err within 16 cycles", name);
         fail_stop();
      end
      check_val({name, " latency"}, 32'd1, cnt);
      check_val({name, " ack with err"}, 32'd0, {31'b0, wb_ack_o & wb_err_o});
      rdat = wb_dat_o;
      got_err = wb_err_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i = 1'b0;
      @(negedge clk);
      check_val({name, " one-shot"}, 32'd0, {30'b0, wb_ack_o, wb_err_o});
   endtask

   task automatic check_frame(input string name, input logic [7:0] tx_byte);
      int cnt;
      for (cnt = 0; cnt <= 2; cnt++) begin
         if (!uart_tx_o) begin
            break;
         end
         @(negedge clk);
      end
      if (cnt > 2) begin
         $display("ERROR: %s start bit did not appear within two cycles", name);
         fail_stop();
      end
      repeat (`UART_DIV / 2) @(negedge clk);
      check_val({name, " start bit"}, 32'd0, {31'b0, uart_tx_o});
      for (int i = 0; i < 8; i++) begin
         repeat (`UART_DIV) @(negedge clk);
         check_val($sformatf("%s data bit %0d", name, i), {31'b0, tx_byte[i]},
                   {31'b0, uart_tx_o});
      end
      repeat (`UART_DIV) @(negedge clk);
      check_val({name, " stop bit"}, 32'd1, {31'b0, uart_tx_o});
   endtask

   // Second TX write lands while the serializer is still busy
   task automatic run_serial(input string name, input logic [31:0] adr,
                             input logic [7:0] tx_byte);
      logic [31:0] rdat;
      logic        err_first;
      logic        err_busy;
      fork
         begin
            bus_cycle({name, " tx write"}, 1'b1, adr, {24'b0, tx_byte}, 4'h1, rdat, err_first);
            check_val({name, " tx write err"}, 32'd0, {31'b0, err_first});
            repeat (2) @(negedge clk);
            bus_cycle({name, " busy write"}, 1'b1, adr, {24'b0, ~tx_byte}, 4'h1, rdat, err_busy);
            check_val({name, " busy write err"}, 32'd1, {31'b0, err_busy});
         end
         check_frame(name, tx_byte);
      join
      repeat (`UART_DIV) @(negedge clk);   // Past the end of the stop bit
   endtask

   task automatic run_vector(input string name, input logic [31:0] op, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [31:0] sel,
                             input logic [31:0] exp_d, input logic [31:0] exp_r);
      logic [31:0] rdat;
      logic        got_err;
      case (op)
         32'd0, 32'd1: begin
            bus_cycle(name, op == 32'd0, adr, dat, sel[3:0], rdat, got_err);
            check_val({name, " err"}, exp_r, {31'b0, got_err});
            if (op == 32'd1 && !got_err) begin
               check_val({name, " read data"}, exp_d, rdat);
            end
         end
         32'd2: run_serial(name, adr, dat[7:0]);
         32'd3: check_val({name, " irq"}, exp_d, irq_o);
         default: begin
            $display("ERROR: %s has an unknown operation %0h", name, op);
            fail_stop();
         end
      endcase
   endtask

   task automatic dm_sweep();
      logic [31:0] rnd;
      logic [31:0] dat;
      logic [31:0] rdat;
      logic        got_err;
      for (int w = 0; w < 16; w++) begin
         dat = $random(seed);
         bus_cycle("sweep init", 1'b1, {22'h0, 4'h4, w[3:0], 2'b00}, dat, 4'hf, rdat, got_err);
         check_val("sweep init err", 32'd0, {31'b0, got_err});
         dm_model[w] = dat;
      end
      for (int i = 0; i < 48; i++) begin
         rnd = $random(seed);
         dat = $random(seed);
         // Random upper address bits make most accesses alias
         if (rnd[30]) begin
            bus_cycle("sweep write", 1'b1, {1'b0, rnd[28:8], 4'h4, rnd[3:0], 2'b00}, dat,
                      rnd[7:4], rdat, got_err);
            dm_model[rnd[3:0]] = merge_bytes(dm_model[rnd[3:0]], dat, rnd[7:4]);
         end else begin
            bus_cycle("sweep read", 1'b0, {1'b0, rnd[28:8], 4'h4, rnd[3:0], 2'b00}, dat,
                      4'hf, rdat, got_err);
            check_val($sformatf("sweep read word %0d", rnd[3:0]), dm_model[rnd[3:0]], rdat);
         end
         check_val("sweep err", 32'd0, {31'b0, got_err});
      end
   endtask

   initial begin
      string       line;
      int          fd;
      int          n;
      int          lineno;
      logic [31:0] op;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [31:0] sel;
      logic [31:0] exp_d;
      logic [31:0] exp_r;
      rst_n_i = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      check_val("reset ack", 32'd0, {31'b0, wb_ack_o});
      check_val("reset err", 32'd0, {31'b0, wb_err_o});
      check_val("reset irq", 32'd0, irq_o);
      check_val("reset tx line", 32'd1, {31'b0, uart_tx_o});

      fd = $fopen("verif/tile_vectors.txt", "r");
      if (fd == 0) begin
         $display("ERROR: the vector file verif/tile_vectors.txt could not be opened");
         fail_stop();
      end
      lineno = 0;
      while ($fgets(line, fd) != 0) begin
         lineno++;
         if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h", op, adr, dat, sel, exp_d, exp_r);
            if (n != 6) begin
               $display("ERROR: vector line %0d does not hold six fields", lineno);
               fail_stop();
            end
            run_vector($sformatf("vector line %0d", lineno), op, adr, dat, sel, exp_d, exp_r);
         end
      end
      $fclose(fd);

      dm_sweep();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* verif/tile_vectors.txt */
# op: 0 write, 1 read, 2 UART frame of the data byte, 3 irq vector check; resp: 0 ack, 1 err
# op adr dat sel exp_dat exp_resp
0 00000080 cafef00d f 00000000 0
1 00000080 00000000 f cafef00d 0
1 00000480 00000000 f cafef00d 0
1 40000080 00000000 f cafef00d 0
0 00000084 12345678 f 00000000 0
0 00000084 0000ab00 2 00000000 0
1 00000084 00000000 f 1234ab78 0
0 e0000000 11111111 f 00000000 1
1 f0000000 00000000 f 00000000 1
1 90000010 00000000 f 00000000 1
0 90000008 00000001 f 00000000 0
1 90000008 00000000 f 00000001 0
3 00000000 00000000 0 00000000 0
1 90000004 00000000 f 00000000 0
2 90000000 000000a5 1 00000000 0
3 00000000 00000000 0 00000004 0
1 90000004 00000000 f 00000002 0
3 00000000 00000000 0 00000000 0
1 90000004 00000000 f 00000000 0
0 90000008 00000000 f 00000000 0
2 90000000 0000003c 1 00000000 0
3 00000000 00000000 0 00000000 0
1 90000004 00000000 f 00000002 0

/* filelist.f */
+incdir+hw
hw/tile_pkg.sv
hw/wb_addr_decode.sv
hw/dm_ram.sv
hw/uart_regs.sv
hw/wb_resp_mux.sv
hw/compute_tile_top.sv
verif/tb_clkgen.sv
verif/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | grep "Simulation completed successfully" ||
{ echo "run_sim: simulation did not pass"; exit 1; }
